// ==== files.f ====
+incdir+include
design/spy_pkg.sv
design/spi_cmd_decoder.sv
design/spy_write_buffer.sv
design/spy_iomem_regs.sv
design/spi_spy_top.sv
verif/tb_clock_gen.sv
verif/tb_spi_spy.sv

// ==== Bender.yml ====
package:
  name: spi_spy

sources:
  - include_dirs:
      - include
    files:
      - design/spy_pkg.sv
      - design/spi_cmd_decoder.sv
      - design/spy_write_buffer.sv
      - design/spy_iomem_regs.sv
      - design/spi_spy_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_spi_spy.sv

// ==== verif/tb_spi_spy.sv ====
// spi spy testbench
`timescale 1ns/10ps
`default_nettype none

`include "spy_params.svh"

module tb_spi_spy;
	import spy_pkg::*;

	localparam int half_cycles = 4;      // clk cycles per spi half period
	localparam int spi_bytes   = 151;    // worst case over all transactions
	localparam int spi_xfers   = 6;
	localparam int bus_ops     = 180;
	localparam int cycle_limit = 2 * (4 + spi_bytes * 16 * half_cycles + spi_xfers * 16 +
		bus_ops * 4);

	localparam bus_word_t gpio_addr  = {`SPY_GPIO_BASE, 20'h0};
	localparam bus_word_t cmd_addr   = {`SPY_REGS_BASE, 12'h0, `SPY_OFS_CMD};
	localparam bus_word_t faddr_addr = {`SPY_REGS_BASE, 12'h0, `SPY_OFS_ADDR};
	localparam bus_word_t len_addr   = {`SPY_REGS_BASE, 12'h0, `SPY_OFS_LEN};
	localparam bus_word_t wbuf_addr  = {`SPY_WBUF_BASE, 20'h0};

	logic clk, resetn;
	logic spi_clk, spi_cs, spi_di, spi_do, spi_do_enable;
	logic iomem_valid, iomem_ready;
	byte_strobe_t iomem_wstrb;
	bus_word_t iomem_addr, iomem_wdata, iomem_rdata, gpio;

	// reference model state
	bus_word_t ref_gpio;
	spi_byte_t ref_cmd, ref_status;
	flash_addr_t ref_addr;
	byte_count_t ref_len;
	int ref_ncmds;
	spi_byte_t ref_buf [256];
	bit ref_buf_ok [256];

	bus_word_t exp_q[$];
	bus_word_t mask_q[$];
	string name_q[$];          // empty name marks a write, not compared
	spi_byte_t tx_q[$];
	spi_byte_t rx_q[$];
	bit en_q[$];

	logic [31:0] lcg_state = 32'd75;
	int checks, errors, test_err0, cycle_cnt;
	string cmp_name;
	bus_word_t cmp_exp, cmp_mask;

	tb_clock_gen clk_gen_i (.clk(clk), .resetn(resetn));

	spi_spy_top dut_i (
		.clk(clk), .resetn(resetn),
		.spi_clk(spi_clk), .spi_cs(spi_cs), .spi_di(spi_di),
		.spi_do(spi_do), .spi_do_enable(spi_do_enable),
		.iomem_valid(iomem_valid), .iomem_wstrb(iomem_wstrb),
		.iomem_addr(iomem_addr), .iomem_wdata(iomem_wdata),
		.iomem_ready(iomem_ready), .iomem_rdata(iomem_rdata),
		.gpio(gpio)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state ^ (lcg_state >> 16);   // fold high bits down
	endfunction

	function automatic spi_byte_t rand_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[7:0];
	endfunction

	// expected read word and the bits that are known
	function automatic bus_word_t ref_read(input bus_word_t a, output bus_word_t mask);
		bus_word_t w;
		int base;
		mask = '1;
		w = '0;
		case (a[31:20])
		`SPY_GPIO_BASE: w = ref_gpio;
		`SPY_REGS_BASE: begin
			if (a[7:0] == `SPY_OFS_CMD) begin
				w = {24'h0, ref_cmd};
				if (ref_ncmds != 0)
					mask = 32'h0000_00ff;   // timestamp checked on its own
			end else if (a[7:0] == `SPY_OFS_ADDR) begin
				w = {8'h0, ref_addr};
			end else if (a[7:0] == `SPY_OFS_LEN) begin
				w = {12'h0, ref_len, ref_status};
			end
		end
		`SPY_WBUF_BASE: begin
			base = a[7:2] * 4;
			for (int l = 0; l < 4; l++) begin
				w[8*l +: 8]    = ref_buf[base + l];
				mask[8*l +: 8] = ref_buf_ok[base + l] ? 8'hff : 8'h00;
			end
		end
		default: w = '0;
		endcase
		return w;
	endfunction

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic expect_equal(input string name, input bus_word_t got, input bus_word_t exp);
		checks++;
		assert (got == exp) else begin
			$display("MISMATCH %s: got %08h, expected %08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_access(input bus_word_t a, input byte_strobe_t strb, input bus_word_t wd,
		input bus_word_t e, input bus_word_t m, input string name, output bus_word_t rd);
		exp_q.push_back(e);
		mask_q.push_back(m);
		name_q.push_back(name);
		iomem_addr  = a;
		iomem_wstrb = strb;
		iomem_wdata = wd;
		iomem_valid = 1'b1;
		tick(1);
		while (!iomem_ready)
			tick(1);
		rd = iomem_rdata;
		iomem_valid = 1'b0;
		iomem_wstrb = '0;
		tick(1);
	endtask

	task automatic write_reg(input bus_word_t a, input byte_strobe_t strb, input bus_word_t wd);
		bus_word_t rd;
		bus_access(a, strb, wd, '0, '0, "", rd);
	endtask

	task automatic check_read(input bus_word_t a, input string name, output bus_word_t rd);
		bus_word_t e, m;
		e = ref_read(a, m);
		bus_access(a, '0, '0, e, m, name, rd);
	endtask

	// one byte, mode 0, msb first
	task automatic shift_byte(input spi_byte_t tx, output spi_byte_t rx, output bit en_ok);
		en_ok = 1'b1;
		for (int i = 7; i >= 0; i--) begin
			spi_di = tx[i];
			tick(half_cycles);
			spi_clk = 1'b1;
			rx[i] = spi_do;
			en_ok = en_ok & spi_do_enable;
			tick(half_cycles);
			spi_clk = 1'b0;
		end
	endtask

	task automatic run_spi_transfer();
		spi_byte_t rx;
		bit en_ok;
		rx_q.delete();
		en_q.delete();
		spi_cs = 1'b0;
		tick(half_cycles);
		foreach (tx_q[i]) begin
			shift_byte(tx_q[i], rx, en_ok);
			rx_q.push_back(rx);
			en_q.push_back(en_ok);
		end
		tick(half_cycles);
		spi_cs = 1'b1;
		tick(1);
		while (!dut_i.cmd_strobe)   // end of decode
			tick(1);
		tick(half_cycles);
	endtask

	// opcode, address if the opcode takes one, then n_data bytes
	task automatic flash_cmd(input spi_byte_t op, input flash_addr_t a, input int n_data);
		spi_byte_t b;
		bit addr_op;
		addr_op = (op == `SPY_OP_PROGRAM) || (op == `SPY_OP_READ) || (op == `SPY_OP_ERASE);
		tx_q.delete();
		tx_q.push_back(op);
		if (addr_op) begin
			for (int i = 0; i < 3; i++)
				tx_q.push_back(a[23 - 8*i -: 8]);
		end
		for (int i = 0; i < n_data; i++) begin
			b = rand_byte();
			tx_q.push_back(b);
			if (op == `SPY_OP_PROGRAM) begin
				ref_buf[i % 256]    = b;
				ref_buf_ok[i % 256] = 1'b1;
			end
		end
		run_spi_transfer();
		ref_cmd  = op;
		ref_addr = addr_op ? a : '0;
		ref_len  = addr_op ? byte_count_t'(n_data) : '0;
		ref_ncmds++;
	endtask

	task automatic check_cmd_regs(output tstamp_t ts);
		bus_word_t rd;
		check_read(cmd_addr, "CMD", rd);
		ts = rd[31:8];
		check_read(faddr_addr, "ADDR", rd);
		check_read(len_addr, "LEN", rd);
	endtask

	task automatic check_buffer();
		bus_word_t rd;
		for (int w = 0; w < 64; w++) begin
			if (ref_buf_ok[4*w] | ref_buf_ok[4*w+1] | ref_buf_ok[4*w+2] | ref_buf_ok[4*w+3])
				check_read(wbuf_addr + w * 4, $sformatf("WBUF[%0d]", w), rd);
		end
	endtask

	task automatic test_done(input string name);
		$display("test %-10s %0d errors", name, errors - test_err0);
		test_err0 = errors;
	endtask

	// compares every bus response against its queued expectation
	always @(posedge clk) begin
		#1;
		if (iomem_ready) begin
			assert (name_q.size() != 0) else begin
				$display("ERROR: bus response arrived with no request outstanding");
				errors++;
			end
			if (name_q.size() != 0) begin
				cmp_name = name_q.pop_front();
				cmp_exp  = exp_q.pop_front();
				cmp_mask = mask_q.pop_front();
				if (cmp_name != "") begin
					checks++;
					assert ((iomem_rdata & cmp_mask) == (cmp_exp & cmp_mask)) else begin
						$display("MISMATCH %s iomem_rdata: got %08h, expected %08h", cmp_name,
							iomem_rdata & cmp_mask, cmp_exp & cmp_mask);
						errors++;
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("ERROR: timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		bus_word_t rd, w;
		byte_strobe_t strb;
		tstamp_t ts1, ts2;
		spi_byte_t s;
		spi_clk     = 1'b0;
		spi_cs      = 1'b1;
		spi_di      = 1'b0;
		iomem_valid = 1'b0;
		iomem_wstrb = '0;
		iomem_addr  = '0;
		iomem_wdata = '0;
		ref_gpio    = '0;
		ref_cmd     = '0;
		ref_addr    = '0;
		ref_len     = '0;
		ref_status  = '0;
		ref_ncmds   = 0;
		wait (resetn === 1'b1);
		tick(1);

		expect_equal("gpio", gpio, '0);
		check_read(gpio_addr, "GPIO", rd);
		check_cmd_regs(ts1);
		check_read(32'h0500_0000, "UNMAPPED", rd);
		test_done("reset");

		for (int i = 0; i < 8; i++) begin
			w = lcg_next();
			rd = lcg_next();
			strb = rd[3:0];
			write_reg(gpio_addr, strb, w);
			for (int l = 0; l < 4; l++) begin
				if (strb[l])
					ref_gpio[8*l +: 8] = w[8*l +: 8];
			end
			check_read(gpio_addr, "GPIO", rd);
			expect_equal("gpio", gpio, ref_gpio);
		end
		test_done("gpio");

		rd = lcg_next();
		flash_cmd(`SPY_OP_PROGRAM, rd[23:0], 1 + (lcg_next() % 64));
		check_cmd_regs(ts1);
		rd = lcg_next();
		flash_cmd(`SPY_OP_PROGRAM, rd[23:0], 1 + (lcg_next() % 64));
		check_cmd_regs(ts2);
		checks++;
		assert (ts2 > ts1) else begin
			$display("ERROR: second command timestamp %06h is not later than first %06h",
				ts2, ts1);
			errors++;
		end
		test_done("program");

		check_buffer();
		test_done("buffer");

		rd = lcg_next();
		flash_cmd(`SPY_OP_READ, rd[23:0], 2);
		check_cmd_regs(ts1);
		check_buffer();
		rd = lcg_next();
		flash_cmd(`SPY_OP_ERASE, rd[23:0], 0);
		check_cmd_regs(ts1);
		flash_cmd(8'h9f, '0, 1);   // not a known opcode
		check_cmd_regs(ts1);
		check_buffer();
		test_done("other_ops");

		s = rand_byte();
		write_reg(len_addr, 4'b0001, {24'h0, s});
		ref_status = s;
		check_read(len_addr, "LEN", rd);
		flash_cmd(`SPY_OP_STATUS, '0, 2);
		for (int i = 1; i <= 2; i++) begin
			expect_equal("spi_do", rx_q[i], s);
			checks++;
			assert (en_q[i]) else begin
				$display("ERROR: spi_do_enable was low while status byte %0d shifted out", i);
				errors++;
			end
		end
		check_cmd_regs(ts1);
		test_done("status");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter real period_ns    = 40.0,
	parameter int  reset_cycles = 4
) (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2.0) clk = ~clk;
	end

	// release just after a rising edge, like the other stimulus
	initial begin
		resetn = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#2 resetn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/spi_spy_top.sv ====
// spi flash spy top level
`timescale 1ns/10ps
`default_nettype none

module spi_spy_top (
	input  logic                  clk,
	input  logic                  resetn,
	// spi bus
	input  logic                  spi_clk,
	input  logic                  spi_cs,
	input  logic                  spi_di,
	output logic                  spi_do,
	output logic                  spi_do_enable,
	// iomem bus
	input  logic                  iomem_valid,
	input  spy_pkg::byte_strobe_t iomem_wstrb,
	input  spy_pkg::bus_word_t    iomem_addr,
	input  spy_pkg::bus_word_t    iomem_wdata,
	output logic                  iomem_ready,
	output spy_pkg::bus_word_t    iomem_rdata,
	output spy_pkg::bus_word_t    gpio
);
	import spy_pkg::*;

	logic cmd_strobe;
	spi_byte_t cmd;
	flash_addr_t addr;
	byte_count_t len;
	spi_byte_t status_byte;
	spi_byte_t status_wdata;
	logic status_wstrobe;
	logic wr_strobe;
	spi_byte_t wr_byte_addr;
	spi_byte_t wr_data;
	buf_word_idx_t rd_idx;
	bus_word_t rd_word;

	spi_cmd_decoder decoder_i (
		.clk            (clk),
		.resetn         (resetn),
		.spi_clk        (spi_clk),
		.spi_cs         (spi_cs),
		.spi_di         (spi_di),
		.status_wdata   (status_wdata),
		.status_wstrobe (status_wstrobe),
		.spi_do         (spi_do),
		.spi_do_enable  (spi_do_enable),
		.cmd_strobe     (cmd_strobe),
		.cmd            (cmd),
		.addr           (addr),
		.len            (len),
		.status_byte    (status_byte),
		.wr_strobe      (wr_strobe),
		.wr_byte_addr   (wr_byte_addr),
		.wr_data        (wr_data)
	);

	// payload bytes in, bus words out
	spy_write_buffer wbuf_i (
		.clk          (clk),
		.wr_strobe    (wr_strobe),
		.wr_byte_addr (wr_byte_addr),
		.wr_data      (wr_data),
		.rd_idx       (rd_idx),
		.rd_word      (rd_word)
	);

	spy_iomem_regs regs_i (
		.clk            (clk),
		.resetn         (resetn),
		.iomem_valid    (iomem_valid),
		.iomem_wstrb    (iomem_wstrb),
		.iomem_addr     (iomem_addr),
		.iomem_wdata    (iomem_wdata),
		.iomem_ready    (iomem_ready),
		.iomem_rdata    (iomem_rdata),
		.gpio           (gpio),
		.cmd_strobe     (cmd_strobe),
		.cmd            (cmd),
		.addr           (addr),
		.len            (len),
		.status_byte    (status_byte),
		.status_wdata   (status_wdata),
		.status_wstrobe (status_wstrobe),
		.rd_idx         (rd_idx),
		.rd_word        (rd_word)
	);

endmodule

`default_nettype wire

// ==== design/spy_iomem_regs.sv ====
// iomem register window
`timescale 1ns/10ps
`default_nettype none

`include "spy_params.svh"

module spy_iomem_regs (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   iomem_valid,
	input  spy_pkg::byte_strobe_t  iomem_wstrb,
	input  spy_pkg::bus_word_t     iomem_addr,
	input  spy_pkg::bus_word_t     iomem_wdata,
	output logic                   iomem_ready,
	output spy_pkg::bus_word_t     iomem_rdata,
	output spy_pkg::bus_word_t     gpio,
	input  logic                   cmd_strobe,
	input  spy_pkg::spi_byte_t     cmd,
	input  spy_pkg::flash_addr_t   addr,
	input  spy_pkg::byte_count_t   len,
	input  spy_pkg::spi_byte_t     status_byte,
	output spy_pkg::spi_byte_t     status_wdata,
	output logic                   status_wstrobe,
	output spy_pkg::buf_word_idx_t rd_idx,
	input  spy_pkg::bus_word_t     rd_word
);
	import spy_pkg::*;

	typedef enum logic [1:0] {
		seq_idle,
		seq_wait_buf,   // one cycle for the buffer read
		seq_respond
	} seq_state_t;

	seq_state_t seq;
	logic gpio_sel;
	logic regs_sel;
	logic wbuf_sel;
	logic start;
	bus_word_t gpio_next;
	bus_word_t regs_rdata;
	tstamp_t ts_count;
	tstamp_t ts_latch;

	assign gpio_sel = iomem_addr[31:20] == `SPY_GPIO_BASE;
	assign regs_sel = iomem_addr[31:20] == `SPY_REGS_BASE;
	assign wbuf_sel = iomem_addr[31:20] == `SPY_WBUF_BASE;
	assign start    = (seq == seq_idle) && iomem_valid;
	assign rd_idx   = iomem_addr[7:2];

	// gpio merged with the strobed lanes
	always_comb begin
		gpio_next = gpio;
		for (int i = 0; i < 4; i++) begin
			if (iomem_wstrb[i])
				gpio_next[8*i +: 8] = iomem_wdata[8*i +: 8];
		end
	end

	always_comb begin
		case (iomem_addr[7:0])
		`SPY_OFS_CMD:  regs_rdata = {ts_latch, cmd};
		`SPY_OFS_ADDR: regs_rdata = {8'h00, addr};
		`SPY_OFS_LEN:  regs_rdata = {12'h000, len, status_byte};
		default:       regs_rdata = '0;
		endcase
	end

	// free-running count, latched when a command ends
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ts_count <= '0;
			ts_latch <= '0;
		end else begin
			ts_count <= ts_count + 1'b1;
			if (cmd_strobe)
				ts_latch <= ts_count;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			seq            <= seq_idle;
			iomem_ready    <= 1'b0;
			status_wstrobe <= 1'b0;
			gpio           <= '0;
		end else begin
			iomem_ready    <= 1'b0;
			status_wstrobe <= 1'b0;
			case (seq)
			seq_idle: begin
				if (iomem_valid && wbuf_sel) begin
					seq <= seq_wait_buf;
				end else if (iomem_valid) begin
					seq         <= seq_respond;
					iomem_ready <= 1'b1;   // unmapped ends here too
					if (gpio_sel)
						gpio <= gpio_next;
					if (regs_sel && iomem_addr[7:0] == `SPY_OFS_LEN && iomem_wstrb[0])
						status_wstrobe <= 1'b1;
				end
			end
			seq_wait_buf: begin
				seq         <= seq_respond;
				iomem_ready <= 1'b1;
			end
			default: seq <= seq_idle;  // respond lasts one cycle
			endcase
		end
	end

	// read data and status byte
	always_ff @(posedge clk) begin
		if (start) begin
			status_wdata <= iomem_wdata[7:0];
			if (gpio_sel)
				iomem_rdata <= gpio_next;
			else if (regs_sel)
				iomem_rdata <= regs_rdata;
			else
				iomem_rdata <= '0;
		end else if (seq == seq_wait_buf) begin
			iomem_rdata <= rd_word;
		end
	end

	ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		iomem_ready |=> !iomem_ready);

endmodule

`default_nettype wire

// ==== design/spy_write_buffer.sv ====
// page program write buffer
`timescale 1ns/10ps
`default_nettype none

`include "spy_params.svh"

module spy_write_buffer (
	input  logic                   clk,
	input  logic                   wr_strobe,
	input  spy_pkg::spi_byte_t     wr_byte_addr,
	input  spy_pkg::spi_byte_t     wr_data,
	input  spy_pkg::buf_word_idx_t rd_idx,
	output spy_pkg::bus_word_t     rd_word
);
	import spy_pkg::*;

	// four byte lanes per word, lane 0 is the low byte
	logic [3:0][7:0] mem [`SPY_WBUF_WORDS];

	buf_word_idx_t wr_idx;
	logic [1:0] wr_lane;

	assign wr_idx  = wr_byte_addr[7:2];
	assign wr_lane = wr_byte_addr[1:0];

	// byte lane write
	always_ff @(posedge clk) begin
		if (wr_strobe)
			mem[wr_idx][wr_lane] <= wr_data;
	end

	// registered word read
	always_ff @(posedge clk) begin
		rd_word <= mem[rd_idx];
	end

endmodule

`default_nettype wire

// ==== design/spi_cmd_decoder.sv ====
// spi flash command decoder
`timescale 1ns/10ps
`default_nettype none

`include "spy_params.svh"

module spi_cmd_decoder (
	input  logic                clk,
	input  logic                resetn,
	input  logic                spi_clk,
	input  logic                spi_cs,
	input  logic                spi_di,
	input  spy_pkg::spi_byte_t  status_wdata,
	input  logic                status_wstrobe,
	output logic                spi_do,
	output logic                spi_do_enable,
	output logic                cmd_strobe,
	output spy_pkg::spi_byte_t  cmd,
	output spy_pkg::flash_addr_t addr,
	output spy_pkg::byte_count_t len,
	output spy_pkg::spi_byte_t  status_byte,
	output logic                wr_strobe,
	output spy_pkg::spi_byte_t  wr_byte_addr,
	output spy_pkg::spi_byte_t  wr_data
);
	import spy_pkg::*;

	logic [`SPY_SYNC_STAGES-1:0] clk_sync;
	logic [`SPY_SYNC_STAGES-1:0] cs_sync;
	logic [`SPY_SYNC_STAGES-1:0] di_sync;
	logic sclk_s;
	logic cs_s;
	logic di_s;
	logic sclk_q;
	logic cs_q;
	logic sclk_rise;
	logic sclk_fall;
	logic cs_rise;

	logic [6:0] shift_q;
	logic [2:0] bit_cnt;
	logic byte_done;
	spi_byte_t rx_byte;
	logic is_addr_op;

	spi_state_t state;
	logic [1:0] addr_cnt;
	spi_byte_t cur_cmd;
	flash_addr_t cur_addr;
	byte_count_t cur_len;
	logic have_cmd;         // a full opcode arrived in this transaction

	spi_byte_t status_q;
	logic [2:0] out_cnt;

	assign sclk_s = clk_sync[`SPY_SYNC_STAGES-1];
	assign cs_s   = cs_sync[`SPY_SYNC_STAGES-1];
	assign di_s   = di_sync[`SPY_SYNC_STAGES-1];

	assign sclk_rise = sclk_s & ~sclk_q;
	assign sclk_fall = ~sclk_s & sclk_q;
	assign cs_rise   = cs_s & ~cs_q;   // end of transaction

	// pin synchronizers and edge history
	always_ff @(posedge clk) begin
		if (!resetn) begin
			clk_sync <= '0;
			cs_sync  <= '1;
			di_sync  <= '0;
			sclk_q   <= 1'b0;
			cs_q     <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[`SPY_SYNC_STAGES-2:0], spi_clk};
			cs_sync  <= {cs_sync[`SPY_SYNC_STAGES-2:0], spi_cs};
			di_sync  <= {di_sync[`SPY_SYNC_STAGES-2:0], spi_di};
			sclk_q   <= sclk_s;
			cs_q     <= cs_s;
		end
	end

	// msb first, the eighth bit comes straight from di_s
	assign rx_byte   = {shift_q, di_s};
	assign byte_done = sclk_rise & ~cs_s & (bit_cnt == 3'd7);
	assign is_addr_op = (rx_byte == `SPY_OP_PROGRAM) || (rx_byte == `SPY_OP_READ) ||
		(rx_byte == `SPY_OP_ERASE);

	always_ff @(posedge clk) begin
		if (!resetn)
			bit_cnt <= '0;
		else if (cs_s)
			bit_cnt <= '0;
		else if (sclk_rise)
			bit_cnt <= bit_cnt + 3'd1;
	end

	always_ff @(posedge clk) begin
		if (sclk_rise)
			shift_q <= {shift_q[5:0], di_s};
	end

	// transaction fsm
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state      <= idle_opcode;
			addr_cnt   <= '0;
			cur_cmd    <= '0;
			cur_addr   <= '0;
			cur_len    <= '0;
			have_cmd   <= 1'b0;
			wr_strobe  <= 1'b0;
			cmd_strobe <= 1'b0;
			cmd        <= '0;
			addr       <= '0;
			len        <= '0;
		end else begin
			wr_strobe  <= 1'b0;
			cmd_strobe <= 1'b0;
			if (cs_rise && have_cmd) begin
				cmd_strobe <= 1'b1;
				cmd        <= cur_cmd;
				addr       <= cur_addr;
				len        <= cur_len;
				have_cmd   <= 1'b0;
			end
			if (cs_s) begin
				state <= idle_opcode;
			end else if (byte_done) begin
				case (state)
				idle_opcode: begin
					cur_cmd  <= rx_byte;
					cur_addr <= '0;
					cur_len  <= '0;
					addr_cnt <= '0;
					have_cmd <= 1'b1;
					if (is_addr_op)
						state <= addr_bytes;
					else if (rx_byte == `SPY_OP_STATUS)
						state <= status_out;
					else
						state <= ignore;
				end
				addr_bytes: begin
					cur_addr <= {cur_addr[15:0], rx_byte};
					addr_cnt <= addr_cnt + 2'd1;
					if (addr_cnt == 2'd2)
						state <= data_bytes;
				end
				data_bytes: begin
					cur_len <= cur_len + 12'd1;
					if (cur_cmd == `SPY_OP_PROGRAM)
						wr_strobe <= 1'b1;
				end
				default: begin
					// status_out and ignore hold until cs rises
				end
				endcase
			end
		end
	end

	// payload byte for the buffer, index wraps at 256
	always_ff @(posedge clk) begin
		if (byte_done && state == data_bytes) begin
			wr_byte_addr <= cur_len[7:0];
			wr_data      <= rx_byte;
		end
	end

	// status register and its shift-out on falling edges
	always_ff @(posedge clk) begin
		if (!resetn) begin
			status_q      <= '0;
			spi_do        <= 1'b0;
			spi_do_enable <= 1'b0;
			out_cnt       <= '0;
		end else begin
			if (status_wstrobe)
				status_q <= status_wdata;
			if (cs_s) begin
				spi_do        <= 1'b0;
				spi_do_enable <= 1'b0;
				out_cnt       <= '0;
			end else if (state == status_out) begin
				spi_do_enable <= 1'b1;
				if (sclk_fall) begin
					spi_do  <= status_q[~out_cnt];  // bit 7 first, wraps to repeat
					out_cnt <= out_cnt + 3'd1;
				end
			end
		end
	end

	assign status_byte = status_q;

	// buffer writes only come from a program payload
	wr_only_program: assert property (@(posedge clk) disable iff (!resetn)
		wr_strobe |-> ($past(state) == data_bytes) && ($past(cur_cmd) == `SPY_OP_PROGRAM));

	strobe_cs_high: assert property (@(posedge clk) disable iff (!resetn)
		cmd_strobe |-> cs_s);

endmodule

`default_nettype wire

// ==== design/spy_pkg.sv ====
// spi spy shared types
`default_nettype none

`include "spy_params.svh"

package spy_pkg;

	typedef logic [31:0] bus_word_t;     // iomem data and address
	typedef logic [7:0]  spi_byte_t;     // opcode, payload, status
	typedef logic [23:0] flash_addr_t;
	typedef logic [11:0] byte_count_t;   // payload bytes per transaction
	typedef logic [`SPY_TSTAMP_W-1:0] tstamp_t;
	typedef logic [$clog2(`SPY_WBUF_WORDS)-1:0] buf_word_idx_t;
	typedef logic [3:0]  byte_strobe_t;  // one per byte lane

	// decoder states, one per phase of a flash transaction
	typedef enum logic [2:0] {
		idle_opcode,
		addr_bytes,
		data_bytes,
		status_out,
		ignore
	} spi_state_t;

endpackage

`default_nettype wire

// ==== include/spy_params.svh ====
// spi spy address map and opcodes
`ifndef SPY_PARAMS_SVH
`define SPY_PARAMS_SVH

// device select, compared against address bits 31:20
`define SPY_GPIO_BASE   12'h030
`define SPY_REGS_BASE   12'h040
`define SPY_WBUF_BASE   12'h041

// offsets inside the spy register block
`define SPY_OFS_CMD     8'h00
`define SPY_OFS_ADDR    8'h04
`define SPY_OFS_LEN     8'h08

// flash opcodes
`define SPY_OP_PROGRAM  8'h02
`define SPY_OP_READ     8'h03
`define SPY_OP_ERASE    8'h20
`define SPY_OP_STATUS   8'h05

`define SPY_SYNC_STAGES 2
`define SPY_WBUF_WORDS  64
`define SPY_TSTAMP_W    24
`endif
